// File: rtl/stream_pkg.sv
// *************************************************************************
// link stream definitions
// tuser width and the bad-frame mark shared by links and monitor streams
// *************************************************************************

package stream_pkg;

    // one tuser bit per word on every link
    localparam int USER_WIDTH = 1;

    // bits of tuser that carry the bad-frame mark
    localparam logic [USER_WIDTH-1:0] USER_BAD_MASK = 1'b1;

    // value forced into the masked bits on a cut frame
    localparam logic [USER_WIDTH-1:0] USER_BAD_VALUE = 1'b1;

endpackage

// File: rtl/monitor_pkg.sv
// *************************************************************************
// monitor side definitions
// tap count and width of the source tag on the merged stream
// *************************************************************************

package monitor_pkg;

    // links A and B
    localparam int NUM_TAPS = 2;

    // tag 0 is link A, tag 1 is link B
    localparam int TAP_ID_WIDTH = 1;

endpackage

// File: rtl/stream_tap.sv
// *************************************************************************
// stream tap
// copies every accepted word of an observed link into a monitor stream;
// frames hit by monitor back-pressure are cut short and closed with a
// bad-marked word, frames starting under back-pressure are dropped
// *************************************************************************
`timescale 1ns/10ps

module stream_tap import stream_pkg::*; #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic [DATA_WIDTH-1:0] tap_tdata,
    input  logic                  tap_tvalid,
    input  logic                  tap_tready,
    input  logic                  tap_tlast,
    input  logic [USER_WIDTH-1:0] tap_tuser,

    output logic [DATA_WIDTH-1:0] out_tdata,
    output logic                  out_tvalid,
    output logic                  out_tlast,
    output logic [USER_WIDTH-1:0] out_tuser,
    input  logic                  out_tready
);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_XFER  = 2'd1;
    localparam logic [1:0] ST_TRUNC = 2'd2;
    localparam logic [1:0] ST_WAIT  = 2'd3;

    logic [1:0]            state_reg;
    logic [1:0]            state_next;
    logic                  frame_reg;
    logic                  frame_next;
    logic                  link_take;
    logic                  fwd_word;
    logic [USER_WIDTH-1:0] last_user_reg;

    // word offered to the output stage this cycle
    logic [DATA_WIDTH-1:0] int_tdata;
    logic                  int_tvalid;
    logic                  int_tlast;
    logic [USER_WIDTH-1:0] int_tuser;
    logic                  int_ready_reg;
    logic                  int_ready_early;

    // output register and skid register
    logic [DATA_WIDTH-1:0] out_tdata_reg;
    logic                  out_tvalid_reg;
    logic                  out_tlast_reg;
    logic [USER_WIDTH-1:0] out_tuser_reg;
    logic [DATA_WIDTH-1:0] skid_tdata_reg;
    logic                  skid_tvalid_reg;
    logic                  skid_tlast_reg;
    logic [USER_WIDTH-1:0] skid_tuser_reg;

    assign link_take = tap_tvalid && tap_tready;

    always_comb begin
        state_next = state_reg;
        frame_next = frame_reg;
        fwd_word   = 1'b0;
        int_tdata  = '0;
        int_tvalid = 1'b0;
        int_tlast  = 1'b0;
        int_tuser  = '0;

        // track link framing regardless of what gets copied
        if (link_take) begin
            frame_next = !tap_tlast;
        end

        case (state_reg)
            ST_IDLE: begin
                if (link_take) begin
                    if (int_ready_reg) begin
                        fwd_word   = 1'b1;
                        state_next = tap_tlast ? ST_IDLE : ST_XFER;
                    end else if (!tap_tlast) begin
                        // no room for the first word, drop the whole frame
                        state_next = ST_WAIT;
                    end
                end
            end
            ST_XFER: begin
                if (link_take) begin
                    if (int_ready_reg) begin
                        fwd_word   = 1'b1;
                        state_next = tap_tlast ? ST_IDLE : ST_XFER;
                    end else begin
                        state_next = ST_TRUNC;
                    end
                end
            end
            ST_TRUNC: begin
                // closing word once the output stage has room again
                if (int_ready_reg) begin
                    int_tvalid = 1'b1;
                    int_tlast  = 1'b1;
                    int_tuser  = (last_user_reg & ~USER_BAD_MASK) |
                                 (USER_BAD_VALUE & USER_BAD_MASK);
                    state_next = frame_next ? ST_WAIT : ST_IDLE;
                end
            end
            default: begin
                // discard the rest of the link frame
                if (link_take && tap_tlast) begin
                    state_next = ST_IDLE;
                end
            end
        endcase

        if (fwd_word) begin
            int_tdata  = tap_tdata;
            int_tvalid = 1'b1;
            int_tlast  = tap_tlast;
            int_tuser  = tap_tuser;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= ST_IDLE;
            frame_reg <= 1'b0;
        end else begin
            state_reg <= state_next;
            frame_reg <= frame_next;
        end
        if (fwd_word) begin
            last_user_reg <= tap_tuser;
        end
    end

    // ready for next cycle unless the skid register would fill up
    assign int_ready_early = out_tready ||
                             (!skid_tvalid_reg && (!out_tvalid_reg || !int_tvalid));

    always_ff @(posedge clk) begin
        if (rst) begin
            int_ready_reg   <= 1'b0;
            out_tvalid_reg  <= 1'b0;
            skid_tvalid_reg <= 1'b0;
        end else begin
            int_ready_reg <= int_ready_early;
            if (int_ready_reg) begin
                if (out_tready || !out_tvalid_reg) begin
                    out_tvalid_reg <= int_tvalid;
                end else begin
                    skid_tvalid_reg <= int_tvalid;
                end
            end else if (out_tready) begin
                out_tvalid_reg  <= skid_tvalid_reg;
                skid_tvalid_reg <= 1'b0;
            end
        end

        if (int_ready_reg && (out_tready || !out_tvalid_reg)) begin
            out_tdata_reg <= int_tdata;
            out_tlast_reg <= int_tlast;
            out_tuser_reg <= int_tuser;
        end else if (!int_ready_reg && out_tready) begin
            out_tdata_reg <= skid_tdata_reg;
            out_tlast_reg <= skid_tlast_reg;
            out_tuser_reg <= skid_tuser_reg;
        end

        if (int_ready_reg && out_tvalid_reg && !out_tready) begin
            skid_tdata_reg <= int_tdata;
            skid_tlast_reg <= int_tlast;
            skid_tuser_reg <= int_tuser;
        end
    end

    assign out_tdata  = out_tdata_reg;
    assign out_tvalid = out_tvalid_reg;
    assign out_tlast  = out_tlast_reg;
    assign out_tuser  = out_tuser_reg;

endmodule

// File: rtl/tap_arbiter.sv
// *************************************************************************
// tap arbiter
// frame-locked round-robin merge of the tap streams into one registered
// monitor output, each frame tagged with its source on mon_tid
// *************************************************************************
`timescale 1ns/10ps

module tap_arbiter import stream_pkg::*, monitor_pkg::*; #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,

    input  logic [DATA_WIDTH-1:0]   a_tdata,
    input  logic                    a_tvalid,
    input  logic                    a_tlast,
    input  logic [USER_WIDTH-1:0]   a_tuser,
    output logic                    a_tready,

    input  logic [DATA_WIDTH-1:0]   b_tdata,
    input  logic                    b_tvalid,
    input  logic                    b_tlast,
    input  logic [USER_WIDTH-1:0]   b_tuser,
    output logic                    b_tready,

    output logic [DATA_WIDTH-1:0]   mon_tdata,
    output logic                    mon_tvalid,
    output logic                    mon_tlast,
    output logic [USER_WIDTH-1:0]   mon_tuser,
    output logic [TAP_ID_WIDTH-1:0] mon_tid,
    input  logic                    mon_tready
);

    logic [DATA_WIDTH-1:0]   in_tdata [NUM_TAPS];
    logic                    in_tvalid [NUM_TAPS];
    logic                    in_tlast [NUM_TAPS];
    logic [USER_WIDTH-1:0]   in_tuser [NUM_TAPS];

    // grant_reg doubles as the last-granted pointer
    logic [TAP_ID_WIDTH-1:0] grant_reg;
    logic [TAP_ID_WIDTH-1:0] other_id;
    logic [TAP_ID_WIDTH-1:0] sel_id;
    logic                    locked_reg;
    logic                    out_free;
    logic                    take;

    assign in_tdata[0]  = a_tdata;
    assign in_tvalid[0] = a_tvalid;
    assign in_tlast[0]  = a_tlast;
    assign in_tuser[0]  = a_tuser;
    assign in_tdata[1]  = b_tdata;
    assign in_tvalid[1] = b_tvalid;
    assign in_tlast[1]  = b_tlast;
    assign in_tuser[1]  = b_tuser;

    assign other_id = grant_reg + 1'b1;

    // hold the grant inside a frame, otherwise prefer the other tap
    always_comb begin
        if (locked_reg || !in_tvalid[other_id]) begin
            sel_id = grant_reg;
        end else begin
            sel_id = other_id;
        end
    end

    assign out_free = !mon_tvalid || mon_tready;
    assign take     = out_free && in_tvalid[sel_id];

    assign a_tready = out_free && (sel_id == TAP_ID_WIDTH'(0));
    assign b_tready = out_free && (sel_id == TAP_ID_WIDTH'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_reg  <= TAP_ID_WIDTH'(NUM_TAPS - 1);
            locked_reg <= 1'b0;
            mon_tvalid <= 1'b0;
        end else begin
            if (take) begin
                grant_reg  <= sel_id;
                locked_reg <= !in_tlast[sel_id];
            end
            if (out_free) begin
                mon_tvalid <= take;
            end
        end

        if (take) begin
            mon_tdata <= in_tdata[sel_id];
            mon_tlast <= in_tlast[sel_id];
            mon_tuser <= in_tuser[sel_id];
            mon_tid   <= sel_id;
        end
    end

endmodule

// File: rtl/stream_monitor.sv
// *************************************************************************
// stream monitor top level
// passive taps on links A and B merged into one tagged monitor stream
// *************************************************************************
`timescale 1ns/10ps

module stream_monitor import stream_pkg::*, monitor_pkg::*; #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                    clk,
    input  logic                    rst,

    // link A, observed only
    input  logic [DATA_WIDTH-1:0]   a_tdata,
    input  logic                    a_tvalid,
    input  logic                    a_tready,
    input  logic                    a_tlast,
    input  logic [USER_WIDTH-1:0]   a_tuser,

    // link B, observed only
    input  logic [DATA_WIDTH-1:0]   b_tdata,
    input  logic                    b_tvalid,
    input  logic                    b_tready,
    input  logic                    b_tlast,
    input  logic [USER_WIDTH-1:0]   b_tuser,

    output logic [DATA_WIDTH-1:0]   mon_tdata,
    output logic                    mon_tvalid,
    output logic                    mon_tlast,
    output logic [USER_WIDTH-1:0]   mon_tuser,
    output logic [TAP_ID_WIDTH-1:0] mon_tid,
    input  logic                    mon_tready
);

    // tap streams into the arbiter
    logic [DATA_WIDTH-1:0] ta_tdata;
    logic                  ta_tvalid;
    logic                  ta_tlast;
    logic [USER_WIDTH-1:0] ta_tuser;
    logic                  ta_tready;
    logic [DATA_WIDTH-1:0] tb_tdata;
    logic                  tb_tvalid;
    logic                  tb_tlast;
    logic [USER_WIDTH-1:0] tb_tuser;
    logic                  tb_tready;

    stream_tap #(.DATA_WIDTH(DATA_WIDTH)) tap_a (
        .clk, .rst,
        .tap_tdata(a_tdata), .tap_tvalid(a_tvalid), .tap_tready(a_tready),
        .tap_tlast(a_tlast), .tap_tuser(a_tuser),
        .out_tdata(ta_tdata), .out_tvalid(ta_tvalid), .out_tlast(ta_tlast),
        .out_tuser(ta_tuser), .out_tready(ta_tready)
    );

    stream_tap #(.DATA_WIDTH(DATA_WIDTH)) tap_b (
        .clk, .rst,
        .tap_tdata(b_tdata), .tap_tvalid(b_tvalid), .tap_tready(b_tready),
        .tap_tlast(b_tlast), .tap_tuser(b_tuser),
        .out_tdata(tb_tdata), .out_tvalid(tb_tvalid), .out_tlast(tb_tlast),
        .out_tuser(tb_tuser), .out_tready(tb_tready)
    );

    tap_arbiter #(.DATA_WIDTH(DATA_WIDTH)) tap_arbiter_i (
        .clk, .rst,
        .a_tdata(ta_tdata), .a_tvalid(ta_tvalid), .a_tlast(ta_tlast),
        .a_tuser(ta_tuser), .a_tready(ta_tready),
        .b_tdata(tb_tdata), .b_tvalid(tb_tvalid), .b_tlast(tb_tlast),
        .b_tuser(tb_tuser), .b_tready(tb_tready),
        .mon_tdata, .mon_tvalid, .mon_tlast, .mon_tuser, .mon_tid, .mon_tready
    );

endmodule

// File: dv/stream_monitor_tb.sv
// *************************************************************************
// stream monitor testbench
// random traffic on links A and B and random monitor back-pressure, with
// every monitor frame checked against the frames accepted on its link
// *************************************************************************
`timescale 1ns/10ps

module stream_monitor_tb
    import stream_pkg::*, monitor_pkg::*;
();

    localparam int DATA_WIDTH = 8;
    localparam int MAX_LEN    = 6;
    localparam int P1_FRAMES  = 200;
    localparam int ALL_FRAMES = 600;
    // ten cycles for every possible link word plus margin
    localparam int MAX_CYCLES = 10 * 2 * ALL_FRAMES * MAX_LEN + 1000;

    typedef struct packed {
        logic [7:0][DATA_WIDTH-1:0] data;
        logic [7:0][USER_WIDTH-1:0] user;
        int                         len;
        logic                       done;
    } frame_t;

    logic                    clk;
    logic                    rst;
    logic [DATA_WIDTH-1:0]   l_data [2];
    logic                    l_valid [2];
    logic                    l_ready [2];
    logic                    l_last [2];
    logic [USER_WIDTH-1:0]   l_user [2];
    logic [DATA_WIDTH-1:0]   mon_tdata;
    logic                    mon_tvalid;
    logic                    mon_tlast;
    logic [USER_WIDTH-1:0]   mon_tuser;
    logic [TAP_ID_WIDTH-1:0] mon_tid;
    logic                    mon_tready;

    // accepted link frames indexed by frame number
    frame_t                  rec [2][ALL_FRAMES];
    frame_t                  got;
    logic [TAP_ID_WIDTH-1:0] got_tid;
    int                      started [2];
    int                      next_exp [2];
    int                      flen [2];
    bit                      active [2];
    bit                      bad [2];
    int                      limit;
    int                      phase;
    int                      idle_cnt;
    int                      cycles = 0;
    int                      errors;
    int                      n_exact;
    int                      n_cut;
    int                      n_missing;
    bit                      seen_word;
    logic [31:0]             rng;

    stream_monitor #(.DATA_WIDTH(DATA_WIDTH)) stream_monitor_i (
        .clk, .rst,
        .a_tdata(l_data[0]), .a_tvalid(l_valid[0]), .a_tready(l_ready[0]),
        .a_tlast(l_last[0]), .a_tuser(l_user[0]),
        .b_tdata(l_data[1]), .b_tvalid(l_valid[1]), .b_tready(l_ready[1]),
        .b_tlast(l_last[1]), .b_tuser(l_user[1]),
        .mon_tdata, .mon_tvalid, .mon_tlast, .mon_tuser, .mon_tid, .mon_tready
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // 2 for an exact copy, 1 for a valid cut frame, 0 otherwise
    function automatic int compare(frame_t e, frame_t g);
        logic [USER_WIDTH-1:0] mark;
        bit                    same;
        bit                    cut;
        same = e.done && (g.len == e.len);
        cut  = (g.len >= 2) && (g.len - 1 < e.len);
        for (int k = 0; k < g.len; k++) begin
            if (g.data[k] != e.data[k] || g.user[k] != e.user[k]) begin
                same = 1'b0;
                if (k < g.len - 1) begin
                    cut = 1'b0;
                end
            end
        end
        if (cut) begin
            // masked bits take the mark, the others keep the last copied word
            for (int b = 0; b < USER_WIDTH; b++) begin
                mark[b] = USER_BAD_MASK[b] ? USER_BAD_VALUE[b] : e.user[g.len - 2][b];
            end
            cut  = (g.data[g.len - 1] == '0) && (g.user[g.len - 1] == mark);
        end
        return same ? 2 : (cut ? 1 : 0);
    endfunction

    task automatic note_missing(input int t, input int n);
        n_missing++;
        // frames may only vanish under monitor back-pressure
        if (n < P1_FRAMES) begin
            errors++;
            $display("link %0d frame %0d never reached the monitor output", t, n);
        end
    endtask

    task automatic check_frame();
        int t;
        int found;
        int kind;
        t     = int'(got_tid);
        found = -1;
        for (int n = next_exp[t]; n < started[t]; n++) begin
            if (found < 0 && DATA_WIDTH'(n) == got.data[0]) begin
                found = n;
            end
        end
        if (got.len > MAX_LEN || found < 0) begin
            errors++;
            $display("monitor frame of %0d words from link %0d matches no link frame",
                     got.len, t);
        end else begin
            for (int n = next_exp[t]; n < found; n++) begin
                note_missing(t, n);
            end
            next_exp[t] = found + 1;
            kind = compare(rec[t][found], got);
            if (kind == 2) begin
                n_exact++;
            end else if (kind == 1 && found >= P1_FRAMES) begin
                n_cut++;
            end else begin
                errors++;
                $write("** Error [frame_copy] link %0d frame %0d: ", t, found);
                $display("expected %0d words %h user %h, got %0d words %h user %h",
                         rec[t][found].len, rec[t][found].data, rec[t][found].user,
                         got.len, got.data, got.user);
            end
        end
    endtask

    task automatic take_word();
        if (got.len == 0) begin
            got_tid = mon_tid;
        end else if (mon_tid != got_tid) begin
            errors++;
            $display("** Error [tid_stable] expected mon_tid %0d, got %0d", got_tid, mon_tid);
        end
        if (got.len < 8) begin
            got.data[got.len] = mon_tdata;
            got.user[got.len] = mon_tuser;
        end
        got.len = got.len + 1;
        if (mon_tlast) begin
            check_frame();
            got = '0;
        end
    endtask

    task automatic step_link(input int i);
        logic [31:0] r;
        int          n;
        int          w;
        // word handed over at the last rising edge
        if (l_valid[i] && l_ready[i]) begin
            l_valid[i] = 1'b0;
            if (l_last[i]) begin
                active[i] = 1'b0;
            end
        end
        r = next_rand();
        // phase one keeps the two links out of each other's frames
        if (!active[i] && started[i] < limit && r[1:0] == 2'd0 &&
                !(phase == 1 && active[1 - i])) begin
            active[i] = 1'b1;
            flen[i]   = int'(r[15:8]) % MAX_LEN + 1;
            bad[i]    = (r[20:18] == 3'd0);
            rec[i][started[i]] = '0;
            started[i]++;
        end
        r = next_rand();
        n = started[i] - 1;
        if (active[i] && !l_valid[i] && r[1:0] != 2'd0) begin
            w = rec[i][n].len;
            l_valid[i] = 1'b1;
            // first word carries the frame number
            l_data[i]  = (w == 0) ? DATA_WIDTH'(n) : DATA_WIDTH'(r >> 8);
            l_last[i]  = (w == flen[i] - 1);
            l_user[i]  = bad[i] ? (USER_BAD_VALUE & USER_BAD_MASK) : '0;
        end
        l_ready[i] = r[2];
        if (l_valid[i] && l_ready[i]) begin
            w = rec[i][n].len;
            rec[i][n].data[w] = l_data[i];
            rec[i][n].user[w] = l_user[i];
            rec[i][n].len     = w + 1;
            rec[i][n].done    = l_last[i];
            seen_word = 1'b1;
        end
    endtask

    task automatic step_cycle();
        logic [31:0] r;
        if (mon_tvalid && !seen_word) begin
            errors++;
            $display("** Error [idle_after_reset] expected mon_tvalid 0, got 1");
        end
        r = next_rand();
        mon_tready = (phase == 2) ? r[0] : 1'b1;
        step_link(0);
        step_link(1);
        idle_cnt = mon_tvalid ? 0 : idle_cnt + 1;
        if (mon_tvalid && mon_tready) begin
            take_word();
        end
    endtask

    task automatic run_phase(input int p, input int frames);
        phase = p;
        limit = frames;
        while (started[0] < limit || started[1] < limit || active[0] || active[1]) begin
            @(negedge clk);
            step_cycle();
        end
        // let the merge empty with mon_tready high
        phase    = 3;
        idle_cnt = 0;
        while (idle_cnt < 32) begin
            @(negedge clk);
            step_cycle();
        end
    endtask

    initial begin
        rng        = 32'h63d9141e;
        rst        = 1'b1;
        mon_tready = 1'b0;
        for (int i = 0; i < 2; i++) begin
            l_data[i]   = '0;
            l_valid[i]  = 1'b0;
            l_ready[i]  = 1'b0;
            l_last[i]   = 1'b0;
            l_user[i]   = '0;
            started[i]  = 0;
            next_exp[i] = 0;
            active[i]   = 1'b0;
        end
        got       = '0;
        got_tid   = '0;
        errors    = 0;
        n_exact   = 0;
        n_cut     = 0;
        n_missing = 0;
        seen_word = 1'b0;
        phase     = 1;
        limit     = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        run_phase(1, P1_FRAMES);
        run_phase(2, ALL_FRAMES);

        for (int t = 0; t < 2; t++) begin
            for (int n = next_exp[t]; n < ALL_FRAMES; n++) begin
                note_missing(t, n);
            end
        end
        if (got.len != 0) begin
            errors++;
            $display("monitor frame of %0d words was never closed by tlast", got.len);
        end
        $display("summary: %0d errors, %0d exact frames, %0d cut frames, %0d missing frames",
                 errors, n_exact, n_cut, n_missing);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: sources.f
rtl/stream_pkg.sv
rtl/monitor_pkg.sv
rtl/stream_tap.sv
rtl/tap_arbiter.sv
rtl/stream_monitor.sv
dv/stream_monitor_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the stream monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -f sources.f --top-module stream_monitor_tb \
    --Mdir obj_dir -o stream_monitor_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/stream_monitor_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^All tests passed!$' sim.log; then
    exit 0
fi
exit 1
